/* verilog/softmax_macros.svh */
`ifndef SOFTMAX_MACROS_SVH
`define SOFTMAX_MACROS_SVH

// vector length, power of two (sorter and tree also fine with 8)
`define SM_N 4

`define SM_W 32
`define SM_FRAC 10

// base-2 conversion constants in Q.10
`define SM_LOG2E 1477
`define SM_LN2 710

// accept edge to out_valid: sort 4 + expsum 4 + ln 2 + res 3
`define SM_LATENCY 13

`endif

/* verilog/softmax_pkg.sv */
`default_nettype none

`include "softmax_macros.svh"

package softmax_pkg;

    // sequencer stages, shared by the controller and the datapath
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_SORT,
        ST_EXPSUM,
        ST_LN,
        ST_RES,
        ST_HOLD
    } sm_stage_e;

    // raw integer score
    typedef logic signed [`SM_W-1:0] score_t;

    // Q22.10
    typedef logic signed [`SM_W-1:0] fix_t;

endpackage

`default_nettype wire

/* verilog/softmax_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface softmax_ctrl_if;

    softmax_pkg::sm_stage_e stage;
    logic                   sort_done; // from max_sort
    logic                   sum_done;  // from sum_add_tree
    logic                   ln_done;   // from ln_unit

    modport ctrl (
        output stage,
        input  sort_done,
        input  sum_done,
        input  ln_done
    );

    modport dp_sort (
        input  stage,
        output sort_done
    );

    modport dp_arith (
        input  stage,
        output sum_done,
        output ln_done
    );

endinterface

`default_nettype wire

/* verilog/softmax_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module softmax_controller (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  logic out_ready,
    output logic in_ready,
    output logic out_valid,
    softmax_ctrl_if.ctrl ctl
);

    localparam logic [1:0] RES_LAST = 2'd2; // 2 exp cycles + output register

    softmax_pkg::sm_stage_e state_q;
    softmax_pkg::sm_stage_e state_d;
    logic [1:0]             res_cnt;

    always_comb begin
        state_d = state_q;
        case (state_q)
            softmax_pkg::ST_IDLE:   if (in_valid) state_d = softmax_pkg::ST_SORT;
            softmax_pkg::ST_SORT:   if (ctl.sort_done) state_d = softmax_pkg::ST_EXPSUM;
            softmax_pkg::ST_EXPSUM: if (ctl.sum_done) state_d = softmax_pkg::ST_LN;
            softmax_pkg::ST_LN:     if (ctl.ln_done) state_d = softmax_pkg::ST_RES;
            softmax_pkg::ST_RES:    if (res_cnt == RES_LAST) state_d = softmax_pkg::ST_HOLD;
            softmax_pkg::ST_HOLD:   if (out_ready) state_d = softmax_pkg::ST_IDLE;
            default:                state_d = softmax_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= softmax_pkg::ST_IDLE;
            res_cnt <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == softmax_pkg::ST_RES) begin
                res_cnt <= res_cnt + 2'd1;
            end else begin
                res_cnt <= '0;
            end
        end
    end

    assign ctl.stage = state_q;
    assign in_ready  = (state_q == softmax_pkg::ST_IDLE);
    assign out_valid = (state_q == softmax_pkg::ST_HOLD);

    // the three datapath blocks never finish on the same cycle
    a_one_done: assert property (@(posedge clk) disable iff (rst)
        $onehot0({ctl.sort_done, ctl.sum_done, ctl.ln_done}));

endmodule

`default_nettype wire

/* verilog/max_sort.sv */
`timescale 1ns/1ps
`default_nettype none

`include "softmax_macros.svh"

module max_sort (
    input  logic clk,
    input  logic rst,
    input  softmax_pkg::score_t [`SM_N-1:0] scores,
    softmax_ctrl_if.dp_sort ctl,
    output softmax_pkg::score_t xmax
);

    localparam int N  = `SM_N;
    localparam int CW = $clog2(N);
    localparam logic [CW-1:0] LAST = CW'(N - 1);

    logic [CW-1:0]       cnt;   // phase number
    softmax_pkg::score_t arr [N];
    softmax_pkg::score_t src [N];
    softmax_pkg::score_t nxt [N];
    logic                active;

    assign active = (ctl.stage == softmax_pkg::ST_SORT);

    // phase 0 works straight on the loaded scores
    always_comb begin
        for (int i = 0; i < N; i++) begin
            src[i] = (cnt == '0) ? scores[i] : arr[i];
        end
        nxt = src;
        for (int i = 0; i + 1 < N; i++) begin
            if ((i % 2) == int'(cnt[0]) && src[i] > src[i+1]) begin // even/odd pairs
                nxt[i]   = src[i+1];
                nxt[i+1] = src[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (active) begin
            cnt <= cnt + 1'b1;
        end else begin
            cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (active) begin
            arr <= nxt;
        end
    end

    assign ctl.sort_done = active && (cnt == LAST);
    assign xmax          = arr[N-1]; // ascending, max at top

    for (genvar g = 0; g < N; g++) begin : g_chk
        a_max: assert property (@(posedge clk) disable iff (rst)
            ctl.sort_done |=> xmax >= scores[g]);
    end

endmodule

`default_nettype wire

/* verilog/exp_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "softmax_macros.svh"

module exp_unit (
    input  logic clk,
    input  logic rst,
    input  softmax_pkg::score_t x,
    input  softmax_pkg::score_t xmax,
    input  softmax_pkg::fix_t lnf,
    input  logic use_ln,
    output softmax_pkg::fix_t y
);

    localparam int W         = `SM_W;
    localparam int FB        = `SM_FRAC;
    localparam int MAX_SHIFT = 20;
    localparam logic signed [2*W-1:0] LOG2E = `SM_LOG2E;

    logic signed [W-1:0]   diff_q10;
    logic signed [W-1:0]   z_in;
    logic signed [2*W-1:0] prod;
    softmax_pkg::fix_t     z_q;     // exponent in base 2, Q.10
    logic signed [W-1:0]   k;
    logic [FB-1:0]         f;
    logic signed [W-1:0]   nk;
    logic [W-1:0]          mant;
    logic [W-1:0]          y_c;

    // stage 1: z = (x - xmax [- lnF]) * log2 e
    always_comb begin
        diff_q10 = (x - xmax) <<< FB;
        z_in     = use_ln ? diff_q10 - lnf : diff_q10;
        prod     = z_in * LOG2E;
    end

    always_ff @(posedge clk) begin
        z_q <= prod[W+FB-1:FB];
    end

    // stage 2: 2^z = (1 + f) * 2^k with k <= 0
    always_comb begin
        k    = z_q >>> FB;
        f    = z_q[FB-1:0];
        nk   = -k;
        mant = W'((1 << FB) + f);
        if (nk > MAX_SHIFT) begin
            y_c = '0; // underflow
        end else if (nk <= 0) begin
            y_c = mant;
        end else begin
            y_c = mant >> nk[4:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            y <= '0;
        end else begin
            y <= softmax_pkg::fix_t'(y_c);
        end
    end

endmodule

`default_nettype wire

/* verilog/sum_add_tree.sv */
`timescale 1ns/1ps
`default_nettype none

`include "softmax_macros.svh"

module sum_add_tree (
    input  logic clk,
    input  logic rst,
    input  softmax_pkg::fix_t [`SM_N-1:0] terms,
    softmax_ctrl_if.dp_arith ctl,
    output softmax_pkg::fix_t f_sum
);

    localparam int N       = `SM_N;
    localparam int LVL     = $clog2(N);
    localparam int EXP_LAT = 2;       // exp outputs settle after this
    localparam int CW      = $clog2(LVL + EXP_LAT);
    localparam logic [CW-1:0] RUN_FROM = CW'(EXP_LAT);
    localparam logic [CW-1:0] LAST     = CW'(EXP_LAT + LVL - 1);

    logic [CW-1:0]     cnt;
    logic              run;
    softmax_pkg::fix_t tree [2*N-1]; // heap order, root at 0

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (ctl.stage == softmax_pkg::ST_EXPSUM) begin
            cnt <= cnt + 1'b1;
        end else begin
            cnt <= '0;
        end
    end

    assign run = (ctl.stage == softmax_pkg::ST_EXPSUM) && (cnt >= RUN_FROM);

    for (genvar i = 0; i < N; i++) begin : g_leaf
        assign tree[N-1+i] = terms[i];
    end

    for (genvar i = 0; i < N - 1; i++) begin : g_node
        softmax_pkg::fix_t sum_q;
        always_ff @(posedge clk) begin
            if (run) begin
                sum_q <= tree[2*i+1] + tree[2*i+2];
            end
        end
        assign tree[i] = sum_q;
    end

    assign ctl.sum_done = (ctl.stage == softmax_pkg::ST_EXPSUM) && (cnt == LAST);
    assign f_sum        = tree[0];

endmodule

`default_nettype wire

/* verilog/ln_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "softmax_macros.svh"

module ln_unit (
    input  logic clk,
    input  logic rst,
    input  softmax_pkg::fix_t f_sum,
    softmax_ctrl_if.dp_arith ctl,
    output softmax_pkg::fix_t lnf
);

    localparam int W  = `SM_W;
    localparam int FB = `SM_FRAC;
    localparam int PW = $clog2(W);
    localparam logic signed [W-1:0] LN2 = `SM_LN2;

    logic                active;
    logic                second;   // second LN cycle
    logic [W-1:0]        f_u;
    logic [PW-1:0]       p_c;
    logic [PW-1:0]       p_q;
    logic [FB-1:0]       m_c;
    logic [FB-1:0]       m_q;
    logic signed [W-1:0] e_c;
    logic signed [W-1:0] log2f;
    logic signed [W-1:0] prod;

    assign active = (ctl.stage == softmax_pkg::ST_LN);

    always_ff @(posedge clk) begin
        if (rst) begin
            second <= 1'b0;
        end else begin
            second <= active && !second;
        end
    end

    // leading one and the ten bits under it
    always_comb begin
        f_u = f_sum;
        p_c = '0;
        for (int i = 0; i < W; i++) begin
            if (f_u[i]) p_c = PW'(i);
        end
        if (p_c >= PW'(FB)) begin
            m_c = FB'(f_u >> (p_c - PW'(FB)));
        end else begin
            m_c = FB'(f_u << (PW'(FB) - p_c));
        end
    end

    always_comb begin
        e_c   = $signed(W'(p_q)) - FB;
        log2f = (e_c <<< FB) + $signed(W'(m_q));
        prod  = log2f * LN2; // ln F = log2 F * ln 2
    end

    always_ff @(posedge clk) begin
        if (active && !second) begin
            p_q <= p_c;
            m_q <= m_c;
        end
        if (active && second) begin
            lnf <= prod >>> FB;
        end
    end

    assign ctl.ln_done = active && second;

endmodule

`default_nettype wire

/* verilog/softmax.sv */
`timescale 1ns/1ps
`default_nettype none

`include "softmax_macros.svh"

module softmax (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  softmax_pkg::score_t [`SM_N-1:0] in_data,
    output logic in_ready,
    output logic out_valid,
    output softmax_pkg::fix_t [`SM_N-1:0] out_data,
    input  logic out_ready
);

    softmax_pkg::score_t [`SM_N-1:0] in_q;
    softmax_pkg::fix_t [`SM_N-1:0]   exp_y;
    softmax_pkg::fix_t [`SM_N-1:0]   out_q;
    softmax_pkg::score_t             xmax;
    softmax_pkg::fix_t               f_sum;
    softmax_pkg::fix_t               lnf;
    logic                            use_ln;

    softmax_ctrl_if ctl ();

    softmax_controller u_softmax_controller (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .ctl       (ctl.ctrl)
    );

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            in_q <= in_data;
        end
    end

    max_sort u_max_sort (
        .clk    (clk),
        .rst    (rst),
        .scores (in_q),
        .ctl    (ctl.dp_sort),
        .xmax   (xmax)
    );

    assign use_ln = (ctl.stage == softmax_pkg::ST_RES); // second pass subtracts ln F

    for (genvar i = 0; i < `SM_N; i++) begin : g_exp
        exp_unit u_exp_unit (
            .clk    (clk),
            .rst    (rst),
            .x      (in_q[i]),
            .xmax   (xmax),
            .lnf    (lnf),
            .use_ln (use_ln),
            .y      (exp_y[i])
        );
    end

    sum_add_tree u_sum_add_tree (
        .clk   (clk),
        .rst   (rst),
        .terms (exp_y),
        .ctl   (ctl.dp_arith),
        .f_sum (f_sum)
    );

    ln_unit u_ln_unit (
        .clk   (clk),
        .rst   (rst),
        .f_sum (f_sum),
        .ctl   (ctl.dp_arith),
        .lnf   (lnf)
    );

    // last capture lands as the stage moves to hold
    always_ff @(posedge clk) begin
        if (use_ln) begin
            out_q <= exp_y;
        end
    end

    assign out_data = out_q;

    // result stays offered and unchanged until taken
    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

/* verif/softmax_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "softmax_macros.svh"

module softmax_tb;

    localparam int N       = `SM_N;
    localparam int NUM_REC = 8;
    localparam int REC_W   = 2 * N;               // scores, then expected outputs
    localparam int RUNS    = 2 * NUM_REC;         // full-rate pass and back-pressure pass
    localparam int TIMEOUT = RUNS * (`SM_LATENCY + 40) + 100;

    logic                        clk;
    logic                        rst;
    logic                        in_valid;
    softmax_pkg::score_t [N-1:0] in_data;
    logic                        in_ready;
    logic                        out_valid;
    softmax_pkg::fix_t [N-1:0]   out_data;
    logic                        out_ready;

    logic [`SM_W-1:0] golden [NUM_REC*REC_W];
    integer           seed;
    int               stalls;   // hold cycles with out_ready low

    softmax i_softmax (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    always #20 clk = ~clk;

    task automatic fail_now();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_fix(input string name, input softmax_pkg::fix_t got,
                             input softmax_pkg::fix_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic present(input int r);
        softmax_pkg::score_t [N-1:0] v;
        for (int i = 0; i < N; i++) begin
            v[i] = golden[r*REC_W + i];
        end
        in_valid <= 1'b1;
        in_data  <= v;
    endtask

    task automatic drive_ready(input bit random_ready);
        if (random_ready) begin
            out_ready <= (($random(seed) & 3) == 0); // high about one cycle in four
        end else begin
            out_ready <= 1'b1;
        end
    endtask

    // entered on a rising edge with vector r already offered
    task automatic run_vector(input int r, input bit random_ready);
        bit taken;
        taken = 1'b0;
        @(negedge clk);
        check_flag("in_ready", in_ready, 1'b1);
        check_flag("out_valid", out_valid, 1'b0);
        @(posedge clk); // accept edge
        if (random_ready && r + 1 < NUM_REC) begin
            present(r + 1); // offered early, must wait for idle
        end else begin
            in_valid <= 1'b0;
        end
        drive_ready(random_ready);
        for (int c = 0; c < `SM_LATENCY; c++) begin
            @(negedge clk);
            check_flag("in_ready", in_ready, 1'b0);
            check_flag("out_valid", out_valid, 1'b0);
            @(posedge clk);
            drive_ready(random_ready);
        end
        // out_valid due right after edge SM_LATENCY
        while (!taken) begin
            @(negedge clk);
            check_flag("out_valid", out_valid, 1'b1);
            check_flag("in_ready", in_ready, 1'b0);
            for (int i = 0; i < N; i++) begin
                check_fix($sformatf("out_data[%0d]", i), out_data[i],
                          golden[r*REC_W + N + i]);
            end
            if (out_ready) begin
                taken = 1'b1;
            end else begin
                stalls++;
            end
            @(posedge clk);
            drive_ready(random_ready);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        seed      = 32'h419d_a34f;
        stalls    = 0;
        $readmemh("verif/softmax_golden.txt", golden);
        if ($isunknown(golden[0]) || $isunknown(golden[NUM_REC*REC_W-1])) begin
            $display("golden file missing or shorter than %0d records", NUM_REC);
            fail_now();
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("in_ready", in_ready, 1'b1);
        check_flag("out_valid", out_valid, 1'b0);
        @(posedge clk);
        for (int r = 0; r < NUM_REC; r++) begin
            present(r);
            run_vector(r, 1'b0);
        end
        present(0);
        for (int r = 0; r < NUM_REC; r++) begin
            run_vector(r, 1'b1);
        end
        if (stalls == 0) begin
            $display("out_ready never stalled a result, back-pressure not exercised");
            fail_now();
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("watchdog expired after %0d cycles, DUT stopped responding", TIMEOUT);
        fail_now();
    end

endmodule

`default_nettype wire

/* softmax.f */
+incdir+verilog
verilog/softmax_pkg.sv
verilog/softmax_ctrl_if.sv
verilog/softmax_controller.sv
verilog/max_sort.sv
verilog/exp_unit.sv
verilog/sum_add_tree.sv
verilog/ln_unit.sv
verilog/softmax.sv
verif/softmax_tb.sv

/* verif/softmax_golden.txt */
// per record, hex: SM_N signed scores, then SM_N expected outputs in Q22.10
// max, F and ln F (decimal, Q.10) noted above each record
// max 5, F 4096, ln F 1420
00000005 00000005 00000005 00000005 000000ff 000000ff 000000ff 000000ff
// max -7, F 4096, ln F 1420
fffffff9 fffffff9 fffffff9 fffffff9 000000ff 000000ff 000000ff 000000ff
// max 10, F 1617, ln F 411
00000007 0000000a 00000008 00000009 00000023 000002d7 00000062 000000fd
// max -20, F 1617, ln F 411
ffffffec ffffffea ffffffeb ffffffe9 000002d7 00000062 000000fd 00000023
// max 100, F 3470, ln F 1202
00000064 00000064 00000063 00000064 0000014e 0000014e 00000077 0000014e
// max 3, F 2048, ln F 710
00000003 00000003 ffffffd8 ffffffd8 000001ff 000001ff 00000000 00000000
// max 1000, F 1024, ln F 0
000003e8 00000000 fffffffb 00000003 00000400 00000000 00000000 00000000
// max 50, F 1024, ln F 0
fffe7960 fffe7960 00000032 fffe7960 00000000 00000000 00000400 00000000
